// File: rtl/apple1_pkg.sv
package apple1_pkg;

    ////////////////////////////////////////////////////////////
    // bus types

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;

    ////////////////////////////////////////////////////////////
    // address map

    // ram lives where these bits are all zero, 0x0000 - 0x1fff
    localparam addr_t RAM_BASE_MASK = 16'hE000;
    // serial port, 0xd010 - 0xd013
    localparam addr_t UART_BASE     = 16'hD010;
    // banner rom, 0xff00 - 0xffff
    localparam addr_t ROM_BASE      = 16'hFF00;

    // line buffer for the echo monitor
    localparam addr_t LINE_BUF_BASE = 16'h0200;
    localparam int    LINE_MAX      = 64;

    // port register offsets
    localparam logic [1:0] REG_KBD   = 2'd0;
    localparam logic [1:0] REG_KBDCR = 2'd1;
    localparam logic [1:0] REG_DSP   = 2'd2;
    localparam logic [1:0] REG_DSPCR = 2'd3;

    localparam byte_t CHAR_CR = 8'h0D;

    ////////////////////////////////////////////////////////////
    // monitor states and bus opcodes

    typedef enum logic [3:0] {
        BOOT,
        BANNER_RD,
        BANNER_WAIT_TX,
        POLL,
        READ_KEY,
        STORE,
        ECHO_WAIT_TX,
        REPLAY_RD,
        REPLAY_WAIT_TX,
        EOL_WAIT_TX
    } mon_state_e;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_READ,
        OP_WRITE
    } bus_op_e;

endpackage

// File: rtl/ram.sv
`timescale 1ns/1ps

module ram (
    input  logic              clk25,
    input  logic [12:0]       address,
    input  logic              w_en,
    input  apple1_pkg::byte_t din,
    output apple1_pkg::byte_t dout
);

    // 8 KiB, contents undefined at power up
    logic [7:0] mem [0:8191];

    always_ff @(posedge clk25)
    begin
        if (w_en)
            mem[address] <= din;
        // registered read, old data on a write cycle
        dout <= mem[address];
    end

endmodule

// File: rtl/banner_rom.sv
`timescale 1ns/1ps

module banner_rom (
    input  logic              clk25,
    input  logic [7:0]        address,
    output apple1_pkg::byte_t dout
);
    import apple1_pkg::*;

    // banner text, first char in the top byte
    localparam int               BANNER_LEN  = 12;
    localparam logic [8*12-1:0]  BANNER_TEXT = "APPLE-1 ECHO";

    int idx;

    assign idx = int'(address);

    always_ff @(posedge clk25)
    begin
        if (idx < BANNER_LEN)
            dout <= BANNER_TEXT[8*(BANNER_LEN-1-idx) +: 8];
        else if (idx == BANNER_LEN)
            dout <= CHAR_CR;
        // terminator
        else if (idx == BANNER_LEN + 1)
            dout <= 8'h00;
        else
            dout <= 8'hFF;
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD_DIV = 217
) (
    input  logic              clk25,
    input  logic              pwr_up_reset,
    input  logic              rx,
    output apple1_pkg::byte_t rx_data,
    output logic              rx_valid
);

    localparam int BW = $clog2(BAUD_DIV);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    rx_sync;
    logic [BW-1:0] timer;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift_reg;

    // lsb first, so the last bit in lands in bit 7
    assign rx_data = shift_reg;

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            rx_sync  <= 2'b11;
            state    <= RX_IDLE;
            rx_valid <= 1'b0;
        end
        else
        begin
            // two flop synchroniser
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE:
                    if (!rx_sync[1])
                    begin
                        // aim at the middle of the start bit
                        timer <= BW'(BAUD_DIV / 2 - 1);
                        state <= RX_START;
                    end
                RX_START:
                    if (timer != '0)
                        timer <= timer - 1'b1;
                    // glitch, line back high
                    else if (rx_sync[1])
                        state <= RX_IDLE;
                    else
                    begin
                        timer   <= BW'(BAUD_DIV - 1);
                        bit_cnt <= '0;
                        state   <= RX_DATA;
                    end
                RX_DATA:
                    if (timer != '0)
                        timer <= timer - 1'b1;
                    else
                    begin
                        shift_reg <= {rx_sync[1], shift_reg[7:1]};
                        timer     <= BW'(BAUD_DIV - 1);
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                RX_STOP:
                    if (timer != '0)
                        timer <= timer - 1'b1;
                    else
                    begin
                        // framing error drops the byte
                        rx_valid <= rx_sync[1];
                        state    <= RX_IDLE;
                    end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk25,
    input  logic                              pwr_up_reset,
    input  logic                              push,
    input  apple1_pkg::byte_t                 push_data,
    input  logic                              pop,
    output apple1_pkg::byte_t                 rd_data,
    output logic                              not_empty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   level
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]    mem [0:FIFO_DEPTH-1];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push_ok;
    logic          pop_ok;

    // full drops, empty pop does nothing
    assign push_ok   = push && (level != FIFO_DEPTH);
    assign pop_ok    = pop && not_empty;
    assign not_empty = (level != '0);
    // head shows without a pop
    assign rd_data   = mem[rd_ptr];

    always_ff @(posedge clk25)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // both at once leaves the count alone
            if (push_ok && !pop_ok)
                level <= level + 1'b1;
            else if (pop_ok && !push_ok)
                level <= level - 1'b1;
        end
    end

endmodule

// File: rtl/uart_port.sv
`timescale 1ns/1ps

module uart_port #(
    parameter int BAUD_DIV   = 217,
    parameter int FIFO_DEPTH = 16,
    parameter int CTS_MARGIN = 4
) (
    input  logic              clk25,
    input  logic              pwr_up_reset,
    input  logic              enable,
    input  logic [1:0]        address,
    input  logic              w_en,
    input  apple1_pkg::byte_t din,
    output apple1_pkg::byte_t dout,
    input  logic              uart_rx,
    output logic              uart_tx,
    output logic              uart_cts
);
    import apple1_pkg::*;

    localparam int BW = $clog2(BAUD_DIV);
    localparam int LW = $clog2(FIFO_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // receive path

    byte_t         rx_data;
    logic          rx_valid;
    byte_t         rd_data;
    logic          not_empty;
    logic [LW-1:0] level;
    logic          pop;

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .rx           (uart_rx),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid)
    );

    rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .push         (rx_valid),
        .push_data    (rx_data),
        .pop          (pop),
        .rd_data      (rd_data),
        .not_empty    (not_empty),
        .level        (level)
    );

    // KBD read consumes the byte
    assign pop      = enable && !w_en && (address == REG_KBD);
    // clear to send while free space stays above the margin
    assign uart_cts = (FIFO_DEPTH - int'(level)) > CTS_MARGIN;

    ////////////////////////////////////////////////////////////
    // transmit path

    logic [9:0]    tx_shift;
    logic [3:0]    tx_bits;
    logic [BW-1:0] tx_timer;
    logic          tx_busy;

    assign tx_busy = (tx_bits != '0);
    assign uart_tx = tx_shift[0];

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            tx_shift <= '1;
            tx_bits  <= '0;
        end
        // stop, data, start; writes while busy are lost
        else if (enable && w_en && (address == REG_DSP) && !tx_busy)
        begin
            tx_shift <= {1'b1, din, 1'b0};
            tx_bits  <= 4'd10;
            tx_timer <= BW'(BAUD_DIV - 1);
        end
        else if (tx_busy)
        begin
            if (tx_timer == '0)
            begin
                tx_shift <= {1'b1, tx_shift[9:1]};
                tx_bits  <= tx_bits - 1'b1;
                tx_timer <= BW'(BAUD_DIV - 1);
            end
            else
                tx_timer <= tx_timer - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // register read

    always_ff @(posedge clk25)
    begin
        case (address)
            REG_KBD:   dout <= rd_data;
            REG_KBDCR: dout <= {not_empty, 7'b0};
            REG_DSP:   dout <= {tx_busy, 7'b0};
            REG_DSPCR: dout <= 8'h00;
            default:   dout <= 8'h00;
        endcase
    end

endmodule

// File: rtl/monitor_engine.sv
`timescale 1ns/1ps

module monitor_engine (
    input  logic                clk25,
    input  logic                cpu_reset,
    input  logic                cpu_clken,
    output apple1_pkg::addr_t   ab,
    output apple1_pkg::byte_t   dbo,
    output logic                we,
    output apple1_pkg::bus_op_e bus_op,
    input  apple1_pkg::byte_t   dbi
);
    import apple1_pkg::*;

    localparam int    IW         = $clog2(LINE_MAX);
    localparam addr_t KBD_ADDR   = {UART_BASE[15:2], REG_KBD};
    localparam addr_t KBDCR_ADDR = {UART_BASE[15:2], REG_KBDCR};
    localparam addr_t DSP_ADDR   = {UART_BASE[15:2], REG_DSP};

    mon_state_e    state;
    logic [7:0]    rom_ptr;
    logic [IW-1:0] line_idx;
    logic [IW-1:0] replay_idx;
    byte_t         tx_char;
    logic          wr_done;

    // access on the bus right now is a write, nothing to sample
    assign wr_done = we;

    // a-z to A-Z
    function automatic byte_t fold_case(input byte_t c);
        if (c >= 8'h61 && c <= 8'h7A)
            return c - 8'h20;
        return c;
    endfunction

    // present the next access
    task automatic issue(input addr_t a, input bus_op_e op, input byte_t d);
        ab     <= a;
        bus_op <= op;
        we     <= (op == OP_WRITE);
        dbo    <= d;
    endtask

    // dbi holds the DSP status here, write once busy has cleared
    task automatic poll_or_send();
        if (dbi[7])
            issue(DSP_ADDR, OP_READ, tx_char);
        else
            issue(DSP_ADDR, OP_WRITE, tx_char);
    endtask

    ////////////////////////////////////////////////////////////
    // state machine, one step per enable

    // state names the access on the bus, dbi is its result
    always_ff @(posedge clk25)
    begin
        if (cpu_reset)
        begin
            state      <= BOOT;
            ab         <= '0;
            bus_op     <= OP_IDLE;
            we         <= 1'b0;
            rom_ptr    <= '0;
            line_idx   <= '0;
            replay_idx <= '0;
        end
        else if (cpu_clken)
        begin
            case (state)
                BOOT:
                begin
                    rom_ptr <= '0;
                    issue(ROM_BASE, OP_READ, tx_char);
                    state <= BANNER_RD;
                end
                // zero byte ends the banner
                BANNER_RD:
                begin
                    if (dbi == 8'h00)
                    begin
                        issue(KBDCR_ADDR, OP_READ, tx_char);
                        state <= POLL;
                    end
                    else
                    begin
                        tx_char <= dbi;
                        issue(DSP_ADDR, OP_READ, dbi);
                        state <= BANNER_WAIT_TX;
                    end
                end
                BANNER_WAIT_TX:
                begin
                    if (wr_done)
                    begin
                        rom_ptr <= rom_ptr + 1'b1;
                        issue({ROM_BASE[15:8], rom_ptr + 8'd1}, OP_READ, tx_char);
                        state <= BANNER_RD;
                    end
                    else
                        poll_or_send();
                end
                // spin on KBDCR bit 7
                POLL:
                begin
                    if (dbi[7])
                    begin
                        issue(KBD_ADDR, OP_READ, tx_char);
                        state <= READ_KEY;
                    end
                    else
                        issue(KBDCR_ADDR, OP_READ, tx_char);
                end
                READ_KEY:
                begin
                    if (dbi == CHAR_CR)
                    begin
                        tx_char    <= CHAR_CR;
                        replay_idx <= '0;
                        // empty line goes straight to the CR
                        if (line_idx == '0)
                        begin
                            issue(DSP_ADDR, OP_READ, CHAR_CR);
                            state <= EOL_WAIT_TX;
                        end
                        else
                        begin
                            issue(LINE_BUF_BASE, OP_READ, CHAR_CR);
                            state <= REPLAY_RD;
                        end
                    end
                    else
                    begin
                        tx_char <= fold_case(dbi);
                        issue(LINE_BUF_BASE + addr_t'(line_idx), OP_WRITE, fold_case(dbi));
                        state <= STORE;
                    end
                end
                // ram write in flight
                STORE:
                begin
                    if (line_idx == IW'(LINE_MAX - 1))
                        line_idx <= '0;
                    else
                        line_idx <= line_idx + 1'b1;
                    issue(DSP_ADDR, OP_READ, tx_char);
                    state <= ECHO_WAIT_TX;
                end
                ECHO_WAIT_TX:
                begin
                    if (wr_done)
                    begin
                        issue(KBDCR_ADDR, OP_READ, tx_char);
                        state <= POLL;
                    end
                    else
                        poll_or_send();
                end
                REPLAY_RD:
                begin
                    tx_char <= dbi;
                    issue(DSP_ADDR, OP_READ, dbi);
                    state <= REPLAY_WAIT_TX;
                end
                // last stored char sent, then the CR
                REPLAY_WAIT_TX:
                begin
                    if (wr_done && (replay_idx + 1'b1 == line_idx))
                    begin
                        tx_char <= CHAR_CR;
                        issue(DSP_ADDR, OP_READ, CHAR_CR);
                        state <= EOL_WAIT_TX;
                    end
                    else if (wr_done)
                    begin
                        replay_idx <= replay_idx + 1'b1;
                        issue(LINE_BUF_BASE + addr_t'(replay_idx + 1'b1), OP_READ, tx_char);
                        state <= REPLAY_RD;
                    end
                    else
                        poll_or_send();
                end
                EOL_WAIT_TX:
                begin
                    if (wr_done)
                    begin
                        line_idx <= '0;
                        issue(KBDCR_ADDR, OP_READ, tx_char);
                        state <= POLL;
                    end
                    else
                        poll_or_send();
                end
                default:
                    state <= BOOT;
            endcase
        end
    end

endmodule

// File: rtl/apple1_system.sv
`timescale 1ns/1ps

module apple1_system #(
    parameter int CLK_DIV    = 25,
    parameter int BAUD_DIV   = 217,
    parameter int FIFO_DEPTH = 16,
    parameter int CTS_MARGIN = 4
) (
    input  logic clk25,
    input  logic pwr_up_reset,
    input  logic uart_rx,
    output logic uart_tx,
    output logic uart_cts
);
    import apple1_pkg::*;

    localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    // processor bus
    addr_t   ab;
    byte_t   dbi;
    byte_t   dbo;
    logic    we;
    bus_op_e bus_op;

    ////////////////////////////////////////////////////////////
    // clock enable

    // one clk25 pulse every CLK_DIV cycles
    logic [DW-1:0] clk_div;
    logic          cpu_clken;

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            clk_div   <= '0;
            cpu_clken <= 1'b0;
        end
        else
        begin
            if (clk_div == DW'(CLK_DIV - 1))
                clk_div <= '0;
            else
                clk_div <= clk_div + 1'b1;
            cpu_clken <= (clk_div == '0);
        end
    end

    ////////////////////////////////////////////////////////////
    // reset stretcher

    // hold the monitor for 63 enable periods after release
    logic [5:0] reset_cnt;
    logic       reset_done;
    logic       cpu_reset;

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            reset_cnt  <= '0;
            reset_done <= 1'b0;
        end
        else if (cpu_clken)
        begin
            if (!(&reset_cnt))
                reset_cnt <= reset_cnt + 1'b1;
            reset_done <= &reset_cnt;
        end
    end

    // active high towards the monitor
    assign cpu_reset = ~reset_done;

    ////////////////////////////////////////////////////////////
    // bus master

    monitor_engine u_monitor (
        .clk25     (clk25),
        .cpu_reset (cpu_reset),
        .cpu_clken (cpu_clken),
        .ab        (ab),
        .dbo       (dbo),
        .we        (we),
        .bus_op    (bus_op),
        .dbi       (dbi)
    );

    ////////////////////////////////////////////////////////////
    // address decode

    logic ram_cs;
    logic uart_cs;
    logic rom_cs;
    logic wr_strobe;

    assign ram_cs    = ((ab & RAM_BASE_MASK) == 16'h0000);
    assign uart_cs   = (ab[15:2] == UART_BASE[15:2]);
    assign rom_cs    = (ab[15:8] == ROM_BASE[15:8]);
    // write only when the opcode agrees
    assign wr_strobe = we & (bus_op == OP_WRITE);

    byte_t ram_dout;
    byte_t rom_dout;
    byte_t uart_dout;

    // one write per access, at the closing enable
    ram u_ram (
        .clk25   (clk25),
        .address (ab[12:0]),
        .w_en    (wr_strobe & ram_cs & cpu_clken),
        .din     (dbo),
        .dout    (ram_dout)
    );

    banner_rom u_rom (
        .clk25   (clk25),
        .address (ab[7:0]),
        .dout    (rom_dout)
    );

    // idle cycles must not pop the keyboard FIFO
    uart_port #(
        .BAUD_DIV   (BAUD_DIV),
        .FIFO_DEPTH (FIFO_DEPTH),
        .CTS_MARGIN (CTS_MARGIN)
    ) u_port (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .enable       (uart_cs & cpu_clken & (bus_op != OP_IDLE)),
        .address      (ab[1:0]),
        .w_en         (wr_strobe & uart_cs),
        .din          (dbo),
        .dout         (uart_dout),
        .uart_rx      (uart_rx),
        .uart_tx      (uart_tx),
        .uart_cts     (uart_cts)
    );

    // read mux, unmapped reads float high
    assign dbi = ram_cs  ? ram_dout  :
                 rom_cs  ? rom_dout  :
                 uart_cs ? uart_dout :
                 8'hFF;

endmodule

// File: sim/uart_host.svh
`ifndef UART_HOST_SVH
`define UART_HOST_SVH

////////////////////////////////////////////////////////////
// host side of the serial link

// 8N1 frame into the DUT, lsb first
task automatic send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    @(posedge clk25);
    // no new start bit while the DUT holds cts low
    while (!uart_cts)
        @(posedge clk25);
    for (int i = 0; i < 10; i++)
    begin
        uart_rx <= frame[i];
        repeat (BAUD_DIV) @(posedge clk25);
    end
endtask

// one frame out of the DUT, sampled at mid-bit
task automatic recv_byte(output byte_t data);
    data = '0;
    @(posedge clk25);
    while (uart_tx !== 1'b0)
        @(posedge clk25);
    // centre of the start bit
    repeat (BAUD_DIV / 2) @(posedge clk25);
    if (uart_tx !== 1'b0)
        stop_on_error("start bit on uart_tx did not last to mid-bit");
    else
    begin
        for (int i = 0; i < 8; i++)
        begin
            repeat (BAUD_DIV) @(posedge clk25);
            data[i] = uart_tx;
        end
        repeat (BAUD_DIV) @(posedge clk25);
        if (uart_tx !== 1'b1)
            stop_on_error("stop bit on uart_tx was low");
    end
endtask

////////////////////////////////////////////////////////////
// compare tasks

task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (expected !== actual)
        stop_on_error($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h",
                                name, expected, actual));
endtask

task automatic check_flag(input string name, input bit expected, input bit actual);
    if (expected !== actual)
        stop_on_error($sformatf("MISMATCH %s expected %0b actual %0b",
                                name, expected, actual));
endtask

`endif

// File: sim/tb_apple1.sv
`timescale 1ns/1ps

module tb_apple1;
    import apple1_pkg::*;

    localparam int CLK_DIV        = 4;
    localparam int BAUD_DIV       = 16;
    // bytes on both serial lines over the whole run, rounded up
    localparam int TOTAL_BYTES    = 440;
    // 10 bit times per byte, 4x margin
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 10 * BAUD_DIV * 4;

    logic clk25 = 1'b0;
    logic pwr_up_reset;
    logic uart_rx;
    logic uart_tx;
    logic uart_cts;

    // expected and received byte streams
    byte_t exp_q[$];
    byte_t rx_q[$];
    // model of the monitor line buffer
    byte_t line_mem [0:LINE_MAX-1];
    int    line_len;
    string banner_text = "APPLE-1 ECHO";

    logic in_burst     = 1'b0;
    logic cts_low_seen = 1'b0;
    int   cycle_cnt    = 0;

    // 40 ns period
    always #20 clk25 = ~clk25;

    apple1_system #(
        .CLK_DIV  (CLK_DIV),
        .BAUD_DIV (BAUD_DIV)
    ) uut (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .uart_rx      (uart_rx),
        .uart_tx      (uart_tx),
        .uart_cts     (uart_cts)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "uart_host.svh"

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic byte_t to_upper(input byte_t c);
        if (c >= "a" && c <= "z")
            return c - 8'h20;
        return c;
    endfunction

    // printable ascii only, never a CR
    function automatic byte_t random_char();
        return byte_t'($urandom_range(8'h7E, 8'h20));
    endfunction

    // banner then CR, after every reset
    task automatic queue_banner();
        for (int i = 0; i < banner_text.len(); i++)
            exp_q.push_back(byte_t'(banner_text[i]));
        exp_q.push_back(CHAR_CR);
    endtask

    // CR replays the stored line, anything else is stored and echoed
    task automatic model_key(input byte_t c);
        if (c == CHAR_CR)
        begin
            for (int i = 0; i < line_len; i++)
                exp_q.push_back(line_mem[i]);
            exp_q.push_back(CHAR_CR);
            line_len = 0;
        end
        else
        begin
            line_mem[line_len] = to_upper(c);
            exp_q.push_back(to_upper(c));
            line_len = (line_len + 1) % LINE_MAX;
        end
    endtask

    task automatic type_key(input byte_t c);
        model_key(c);
        send_byte(c);
    endtask

    // pair up received bytes with the model, in order
    task automatic drain_expected(input string name);
        byte_t want;
        byte_t got;
        int    n;
        n = 0;
        while (exp_q.size() > 0)
        begin
            @(posedge clk25);
            if (rx_q.size() > 0)
            begin
                want = exp_q.pop_front();
                got  = rx_q.pop_front();
                check_byte($sformatf("%s[%0d]", name, n), want, got);
                n++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // background processes

    // collect everything the DUT sends
    initial
    begin
        byte_t b;
        wait (pwr_up_reset === 1'b1);
        forever
        begin
            recv_byte(b);
            rx_q.push_back(b);
        end
    end

    always @(posedge clk25)
    begin
        if (in_burst && !uart_cts)
            cts_low_seen <= 1'b1;
    end

    always @(posedge clk25)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, run still busy after %0d clk25 cycles",
                                    TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////////////////////////
    // test sequence

    initial
    begin
        int    len;
        byte_t c;
        pwr_up_reset <= 1'b0;
        uart_rx      <= 1'b1;
        line_len = 0;
        void'($urandom(78969));
        repeat (2) @(posedge clk25);
        pwr_up_reset <= 1'b1;

        // idle lines after reset, then the banner
        @(posedge clk25);
        check_flag("reset_uart_tx_high", 1'b1, uart_tx);
        check_flag("reset_uart_cts_high", 1'b1, uart_cts);
        queue_banner();
        drain_expected("banner");

        // single keys, one echo each
        for (int i = 0; i < 40; i++)
        begin
            type_key(random_char());
            drain_expected($sformatf("echo_%0d", i));
        end
        // close that line so the next starts at index 0
        type_key(CHAR_CR);
        drain_expected("echo_line_replay");

        // random line then CR
        len = $urandom_range(63, 1);
        for (int i = 0; i < len; i++)
            type_key(random_char());
        type_key(CHAR_CR);
        drain_expected("line_replay");

        // back-to-back burst
        // CR mid burst stalls the monitor in replay, FIFO backs up
        in_burst <= 1'b1;
        for (int i = 0; i < 30; i++)
        begin
            if (i == 14)
                c = CHAR_CR;
            else
                c = random_char();
            type_key(c);
        end
        drain_expected("burst");
        in_burst <= 1'b0;
        check_flag("burst_cts_low_seen", 1'b1, cts_low_seen);

        // reset mid line
        for (int i = 0; i < 5; i++)
            type_key(random_char());
        drain_expected("pre_reset_echo");
        @(posedge clk25);
        pwr_up_reset <= 1'b0;
        repeat (2) @(posedge clk25);
        pwr_up_reset <= 1'b1;
        line_len = 0;
        queue_banner();
        drain_expected("reboot_banner");
        // line index cleared, replay is just the CR
        type_key(CHAR_CR);
        drain_expected("empty_replay");

        // quiet line, nothing extra may show up
        repeat (20 * BAUD_DIV) @(posedge clk25);
        if (rx_q.size() == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
            stop_on_error($sformatf("%0d unexpected bytes received on uart_tx",
                                    rx_q.size()));
    end

endmodule

// File: files.f
+incdir+sim
rtl/apple1_pkg.sv
rtl/ram.sv
rtl/banner_rom.sv
rtl/uart_rx.sv
rtl/rx_fifo.sv
rtl/uart_port.sv
rtl/monitor_engine.sv
rtl/apple1_system.sv
sim/tb_apple1.sv

// File: run_sim.sh
#!/bin/sh
# build and run the apple1 testbench with verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_apple1 -o tb_apple1 \
    && ./obj_dir/tb_apple1 | tee sim.log
# the log decides the result
grep -qF '** PASS **' sim.log && echo "run passed" || { echo "run failed"; exit 1; }
